// File: tiny_bcam.f
+incdir+hw
hw/bcam_pkg.sv
hw/bcam_csr.sv
hw/bcam_entry_store.sv
hw/bcam_match.sv
hw/tiny_bcam_top.sv
bench/tiny_bcam_checker.sv
bench/tiny_bcam_asserts.sv
bench/tiny_bcam_tb.sv

// File: Makefile
TOP := tiny_bcam_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tiny_bcam.f --top-module $(TOP)
	verilator --lint-only -f tiny_bcam.f hw/tiny_bcam_top.sv --top-module tiny_bcam_top

sim:
	verilator --binary --timing --assert -f tiny_bcam.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tiny_bcam_tb.sv
/* tiny BCAM testbench: clock, reset, stimulus table, register tasks,
   watchdog and the DUT with its checker */
`timescale 1ns/100ps
`include "bcam_defs.svh"

module tiny_bcam_tb;
    import bcam_pkg::*;

    localparam int          ROWS         = 12;
    localparam int          RESET_CYCLES = 16;
    localparam logic [1:0]  OP_WRITE     = 2'd0;
    localparam logic [1:0]  OP_READ      = 2'd1;
    localparam logic [1:0]  OP_LOOKUP    = 2'd2;
    localparam logic [1:0]  OP_CLEAR     = 2'd3;

    typedef struct packed {
        logic [1:0]             op;
        logic [`BCAM_ID_W-1:0]  id;
        bcam_entry_t            ent;
    } stim_row_t;

    logic                       core_clk_ifc;
    logic                       reset;
    logic                       reg_wr;
    logic                       reg_rd;
    logic [`BCAM_ADDR_W-1:0]    reg_addr;
    logic [`BCAM_REG_W-1:0]     reg_wdata;
    logic [`BCAM_REG_W-1:0]     reg_rdata;
    logic                       lookup_valid;
    logic [`BCAM_KEY_W-1:0]     lookup_key;
    logic                       result_valid;
    bcam_result_t               result;
    int                         check_errors;
    int                         bench_errors;
    stim_row_t                  rows [ROWS];

    tiny_bcam_top dut0 (.*);

    tiny_bcam_checker chk0 (
        .core_clk_ifc   (core_clk_ifc),
        .reset          (reset),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .lookup_valid   (lookup_valid),
        .lookup_key     (lookup_key),
        .result_valid   (result_valid),
        .result         (result),
        .errors         (check_errors)
    );

    bind tiny_bcam_top tiny_bcam_asserts asserts0 (
        .core_clk_ifc   (core_clk_ifc),
        .reset          (reset),
        .rd_cmd         (rd_cmd),
        .wr_cmd         (wr_cmd),
        .clear_cmd      (clear_cmd),
        .lookup_valid   (lookup_valid),
        .result_valid   (result_valid)
    );

    always #10 core_clk_ifc = ~core_clk_ifc;

    //////////////////////////////////////////////////////////////////////
    // register and lookup tasks
    //////////////////////////////////////////////////////////////////////

    task automatic reg_write(int addr, logic [31:0] data);
        @(negedge core_clk_ifc);
        reg_wr    = 1'b1;
        reg_addr  = `BCAM_ADDR_W'(addr);
        reg_wdata = data;
        @(negedge core_clk_ifc);
        reg_wr    = 1'b0;
    endtask

    task automatic reg_read(int addr, output logic [31:0] data);
        @(negedge core_clk_ifc);
        reg_rd   = 1'b1;
        reg_addr = `BCAM_ADDR_W'(addr);
        @(negedge core_clk_ifc);
        reg_rd   = 1'b0;
        data     = reg_rdata;
    endtask

    task automatic read_counters();
        logic [31:0] d;
        reg_read(`BCAM_REG_LOOKUP_CNT, d);
        reg_read(`BCAM_REG_HIT_CNT, d);
        reg_read(`BCAM_REG_MISS_CNT, d);
    endtask

    task automatic write_entry(logic [`BCAM_ID_W-1:0] id, bcam_entry_t ent);
        reg_write(`BCAM_REG_ENTRY_ID, 32'(id));
        reg_write(`BCAM_REG_DATA0, 32'(ent.key));
        reg_write(`BCAM_REG_DATA0 + 2, ent.value[31:0]);
        reg_write(`BCAM_REG_DATA0 + 3, ent.value[63:32]);
        reg_write(`BCAM_REG_CTRL, {ent.in_use, 29'b0, 2'b10});
        repeat (2) @(negedge core_clk_ifc);
    endtask

    // checker compares every field that is read back
    task automatic read_entry(logic [`BCAM_ID_W-1:0] id);
        logic [31:0] d;
        reg_write(`BCAM_REG_ENTRY_ID, 32'(id));
        reg_write(`BCAM_REG_CTRL, 32'h1);
        repeat (3) @(negedge core_clk_ifc);
        reg_read(`BCAM_REG_CTRL, d);
        reg_read(`BCAM_REG_DATA0, d);
        reg_read(`BCAM_REG_DATA0 + 2, d);
        reg_read(`BCAM_REG_DATA0 + 3, d);
    endtask

    // row key and a random key on back-to-back cycles
    task automatic lookup_pair(logic [`BCAM_KEY_W-1:0] key);
        @(negedge core_clk_ifc);
        lookup_valid = 1'b1;
        lookup_key   = key;
        @(negedge core_clk_ifc);
        lookup_key   = `BCAM_KEY_W'($urandom);
        @(negedge core_clk_ifc);
        lookup_valid = 1'b0;
        repeat (3) @(negedge core_clk_ifc);
        read_counters();
    endtask

    task automatic clear_table();
        logic [31:0] d;
        int          polls;
        reg_write(`BCAM_REG_CTRL, 32'h1 << `BCAM_CTRL_RST);
        reg_read(`BCAM_REG_CTRL, d);
        if (!d[`BCAM_CTRL_RST]) begin
            bench_errors++;
            $display("clear bit did not read back as busy after the clear command");
        end
        polls = 0;
        while (d[`BCAM_CTRL_RST] && polls < 40) begin
            reg_read(`BCAM_REG_CTRL, d);
            polls++;
        end
        if (d[`BCAM_CTRL_RST]) begin
            bench_errors++;
            $display("clear sweep did not finish within 40 polls");
        end
        read_counters();
        read_entry(5'd3);
        read_entry(5'd7);
        read_entry(5'd10);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] d;
        core_clk_ifc = 1'b0;
        reset        = 1'b1;
        reg_wr       = 1'b0;
        reg_rd       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        lookup_valid = 1'b0;
        lookup_key   = '0;
        bench_errors = 0;
        void'($urandom(32'h4894));

        rows[0]  = '{OP_WRITE,  5'd3,  '{1'b1, 20'h12345, 64'h0123_4567_89ab_cdef}};
        rows[1]  = '{OP_WRITE,  5'd7,  '{1'b1, 20'h12345, 64'hfeed_0000_0000_0007}};
        rows[2]  = '{OP_WRITE,  5'd10, '{1'b1, 20'habcde, 64'h5555_aaaa_3333_cccc}};
        rows[3]  = '{OP_WRITE,  5'd12, '{1'b0, 20'h00042, 64'h0000_0042_0000_0042}};
        rows[4]  = '{OP_READ,   5'd3,  '0};
        rows[5]  = '{OP_READ,   5'd12, '0};
        rows[6]  = '{OP_LOOKUP, 5'd0,  '{1'b0, 20'h12345, 64'h0}};
        rows[7]  = '{OP_LOOKUP, 5'd0,  '{1'b0, 20'habcde, 64'h0}};
        rows[8]  = '{OP_LOOKUP, 5'd0,  '{1'b0, 20'h00042, 64'h0}};
        rows[9]  = '{OP_LOOKUP, 5'd0,  '{1'b0, `BCAM_KEY_W'($urandom), 64'h0}};
        rows[10] = '{OP_CLEAR,  5'd0,  '0};
        rows[11] = '{OP_LOOKUP, 5'd0,  '{1'b0, 20'h12345, 64'h0}};

        repeat (RESET_CYCLES) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        reset = 1'b0;

        // scratch register round trip
        reg_write(`BCAM_REG_EMU_MODE, 32'hc0de_4894);
        reg_read(`BCAM_REG_EMU_MODE, d);

        for (int r = 0; r < ROWS; r++) begin
            case (rows[r].op)
                OP_WRITE:  write_entry(rows[r].id, rows[r].ent);
                OP_READ:   read_entry(rows[r].id);
                OP_LOOKUP: lookup_pair(rows[r].ent.key);
                default:   clear_table();
            endcase
        end

        repeat (4) @(negedge core_clk_ifc);
        $display("errors: %0d from checker, %0d from bench", check_errors, bench_errors);
        if (check_errors == 0 && bench_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // budget of 60 cycles per table row plus reset
    initial begin
        #(ROWS * 60 * 20 + RESET_CYCLES * 20);
        $display("timeout: stimulus did not complete in the allotted time");
        $display("Test failed");
        $finish;
    end

endmodule

// File: bench/tiny_bcam_asserts.sv
/* concurrent checks on table command pulses, lookup latency and
   control outputs after reset */
`timescale 1ns/100ps

module tiny_bcam_asserts (
    input logic core_clk_ifc,
    input logic reset,
    input logic rd_cmd,
    input logic wr_cmd,
    input logic clear_cmd,
    input logic lookup_valid,
    input logic result_valid
);

    // a command pulse is never followed by another one
    cmd_single_pulse: assert property (
        @(posedge core_clk_ifc) disable iff (reset)
        (rd_cmd || wr_cmd) |=> !(rd_cmd || wr_cmd)
    ) else $error("table command high on two consecutive cycles");

    // fixed two-cycle lookup latency
    result_latency: assert property (
        @(posedge core_clk_ifc) disable iff (reset)
        result_valid == $past(lookup_valid, 2)
    ) else $error("result_valid does not follow lookup_valid by 2 cycles");

    // first cycle out of reset
    outputs_after_reset: assert property (
        @(posedge core_clk_ifc)
        $fell(reset) |-> (!rd_cmd && !wr_cmd && !clear_cmd && !result_valid)
    ) else $error("control outputs not 0 in the cycle after reset");

endmodule

// File: bench/tiny_bcam_checker.sv
/* reference model of the BCAM registers and table, compares register
   read data and lookup results against it and counts errors */
`timescale 1ns/100ps
`include "bcam_defs.svh"

module tiny_bcam_checker (
    input  logic                        core_clk_ifc,
    input  logic                        reset,
    input  logic                        reg_wr,
    input  logic                        reg_rd,
    input  logic [`BCAM_ADDR_W-1:0]     reg_addr,
    input  logic [`BCAM_REG_W-1:0]      reg_wdata,
    input  logic [`BCAM_REG_W-1:0]      reg_rdata,
    input  logic                        lookup_valid,
    input  logic [`BCAM_KEY_W-1:0]      lookup_key,
    input  logic                        result_valid,
    input  bcam_pkg::bcam_result_t      result,
    output int                          errors
);
    import bcam_pkg::*;

    bcam_entry_t                tbl [`BCAM_DEPTH];
    bcam_entry_t                stg;
    logic [`BCAM_ID_W-1:0]      id;
    logic [`BCAM_REG_W-1:0]     emu;
    logic [`BCAM_REG_W-1:0]     cnt_lookup;
    logic [`BCAM_REG_W-1:0]     cnt_hit;
    logic [`BCAM_REG_W-1:0]     cnt_miss;
    logic [`BCAM_REG_W-1:0]     exp_rdata;
    logic                       rd_pend;
    logic                       rd_q;
    logic                       wr_q;
    logic                       load_q;
    logic                       clr_q;
    int                         busy_left;
    int                         cycle;
    bcam_result_t               exp_q [$];
    int                         stamp_q [$];

    // lowest in-use entry with an equal key wins
    function automatic bcam_result_t model_lookup(logic [`BCAM_KEY_W-1:0] key);
        bcam_result_t r;
        r = '0;
        for (int i = `BCAM_DEPTH - 1; i >= 0; i--) begin
            if (tbl[i].in_use && tbl[i].key == key) begin
                r.hit   = 1'b1;
                r.id    = `BCAM_ID_W'(i);
                r.value = tbl[i].value;
            end
        end
        return r;
    endfunction

    function automatic logic [`BCAM_REG_W-1:0] model_rdata(logic [`BCAM_ADDR_W-1:0] a);
        case (a)
            `BCAM_ADDR_W'(`BCAM_REG_CTRL):
                return {stg.in_use, 28'b0, busy_left > 0, wr_q, rd_q};
            `BCAM_ADDR_W'(`BCAM_REG_ENTRY_ID):   return `BCAM_REG_W'(id);
            `BCAM_ADDR_W'(`BCAM_REG_EMU_MODE):   return emu;
            `BCAM_ADDR_W'(`BCAM_REG_LOOKUP_CNT): return cnt_lookup;
            `BCAM_ADDR_W'(`BCAM_REG_HIT_CNT):    return cnt_hit;
            `BCAM_ADDR_W'(`BCAM_REG_MISS_CNT):   return cnt_miss;
            `BCAM_ADDR_W'(`BCAM_REG_DATA0):      return `BCAM_REG_W'(stg.key);
            `BCAM_ADDR_W'(`BCAM_REG_DATA0 + 2):  return stg.value[31:0];
            `BCAM_ADDR_W'(`BCAM_REG_DATA0 + 3):  return stg.value[63:32];
            default:                             return '0;
        endcase
    endfunction

    task automatic check_field(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic apply_write();
        case (reg_addr)
            `BCAM_ADDR_W'(`BCAM_REG_CTRL): begin
                stg.in_use = reg_wdata[`BCAM_CTRL_IN_USE];
                if (reg_wdata[`BCAM_CTRL_WR]) begin
                    wr_q = 1'b1;
                    // store drops writes during the sweep
                    if (busy_left == 0)
                        tbl[id] = stg;
                end else if (reg_wdata[`BCAM_CTRL_RD]) begin
                    rd_q = 1'b1;
                end
                if (reg_wdata[`BCAM_CTRL_RST]) begin
                    clr_q     = 1'b1;
                    busy_left = `BCAM_DEPTH + 1;
                    for (int i = 0; i < `BCAM_DEPTH; i++)
                        tbl[i].in_use = 1'b0;
                end
            end
            `BCAM_ADDR_W'(`BCAM_REG_ENTRY_ID):  id = reg_wdata[`BCAM_ID_W-1:0];
            `BCAM_ADDR_W'(`BCAM_REG_EMU_MODE):  emu = reg_wdata;
            `BCAM_ADDR_W'(`BCAM_REG_DATA0):     stg.key = reg_wdata[`BCAM_KEY_W-1:0];
            `BCAM_ADDR_W'(`BCAM_REG_DATA0 + 2): stg.value[31:0] = reg_wdata;
            `BCAM_ADDR_W'(`BCAM_REG_DATA0 + 3): stg.value[63:32] = reg_wdata;
            default: ;
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // per-cycle model update and compare
    //////////////////////////////////////////////////////////////////////

    initial errors = 0;

    always @(posedge core_clk_ifc) begin
        bcam_result_t exp_res;
        if (reset) begin
            for (int i = 0; i < `BCAM_DEPTH; i++)
                tbl[i] = '0;
            stg        = '0;
            id         = '0;
            emu        = '0;
            cnt_lookup = '0;
            cnt_hit    = '0;
            cnt_miss   = '0;
            rd_pend    = 1'b0;
            rd_q       = 1'b0;
            wr_q       = 1'b0;
            load_q     = 1'b0;
            clr_q      = 1'b0;
            busy_left  = 0;
            cycle      = 0;
            exp_q.delete();
            stamp_q.delete();
        end else begin
            // read data from the previous strobe is now stable
            if (rd_pend)
                check_field("reg_rdata", 64'(reg_rdata), 64'(exp_rdata));
            rd_pend = reg_rd;
            if (reg_rd)
                exp_rdata = model_rdata(reg_addr);

            // each lookup is due back exactly 2 cycles after it was issued
            if (stamp_q.size() != 0 && cycle - stamp_q[0] == 2) begin
                exp_res = exp_q.pop_front();
                void'(stamp_q.pop_front());
                if (!result_valid) begin
                    errors++;
                    $display("result_valid missing 2 cycles after a lookup");
                end else begin
                    check_field("result.hit", 64'(result.hit), 64'(exp_res.hit));
                    check_field("result.id", 64'(result.id), 64'(exp_res.id));
                    check_field("result.value", result.value, exp_res.value);
                end
                cnt_lookup++;
                if (exp_res.hit)
                    cnt_hit++;
                else
                    cnt_miss++;
            end else if (result_valid) begin
                errors++;
                $display("result_valid seen with no lookup issued 2 cycles before");
            end

            // command effects, one edge behind the control write
            if (load_q)
                stg = tbl[id];
            load_q = rd_q;
            if (clr_q) begin
                cnt_lookup = '0;
                cnt_hit    = '0;
                cnt_miss   = '0;
            end
            if (busy_left > 0)
                busy_left--;
            rd_q  = 1'b0;
            wr_q  = 1'b0;
            clr_q = 1'b0;

            if (reg_wr)
                apply_write();
            if (lookup_valid) begin
                exp_q.push_back(model_lookup(lookup_key));
                stamp_q.push_back(cycle);
            end
            cycle++;
        end
    end

endmodule

// File: hw/tiny_bcam_top.sv
/* tiny BCAM top: register block, entry store and match pipeline */
`timescale 1ns/100ps
`include "bcam_defs.svh"

module tiny_bcam_top (
    input  logic                        core_clk_ifc,
    input  logic                        reset,
    input  logic                        reg_wr,
    input  logic                        reg_rd,
    input  logic [`BCAM_ADDR_W-1:0]     reg_addr,
    input  logic [`BCAM_REG_W-1:0]      reg_wdata,
    output logic [`BCAM_REG_W-1:0]      reg_rdata,
    input  logic                        lookup_valid,
    input  logic [`BCAM_KEY_W-1:0]      lookup_key,
    output logic                        result_valid,
    output bcam_pkg::bcam_result_t      result
);
    import bcam_pkg::*;

    // table command path
    logic                           rd_cmd;
    logic                           wr_cmd;
    logic                           clear_cmd;
    logic                           clear_busy;
    logic [`BCAM_ID_W-1:0]          cmd_id;
    bcam_entry_t                    wr_entry;
    bcam_entry_t                    rd_entry;
    bcam_entry_t [`BCAM_DEPTH-1:0]  table_entries;

    // counters back to the register block
    logic [`BCAM_REG_W-1:0]         lookup_cnt;
    logic [`BCAM_REG_W-1:0]         hit_cnt;
    logic [`BCAM_REG_W-1:0]         miss_cnt;

    bcam_csr csr0 (
        .core_clk_ifc   (core_clk_ifc),
        .reset          (reset),
        .reg_wr         (reg_wr),
        .reg_rd         (reg_rd),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .rd_entry       (rd_entry),
        .clear_busy     (clear_busy),
        .lookup_cnt     (lookup_cnt),
        .hit_cnt        (hit_cnt),
        .miss_cnt       (miss_cnt),
        .rd_cmd         (rd_cmd),
        .wr_cmd         (wr_cmd),
        .clear_cmd      (clear_cmd),
        .cmd_id         (cmd_id),
        .wr_entry       (wr_entry)
    );

    bcam_entry_store store0 (
        .core_clk_ifc   (core_clk_ifc),
        .reset          (reset),
        .rd_cmd         (rd_cmd),
        .wr_cmd         (wr_cmd),
        .clear_cmd      (clear_cmd),
        .cmd_id         (cmd_id),
        .wr_entry       (wr_entry),
        .rd_entry       (rd_entry),
        .clear_busy     (clear_busy),
        .table_entries  (table_entries)
    );

    bcam_match match0 (
        .core_clk_ifc   (core_clk_ifc),
        .reset          (reset),
        .lookup_valid   (lookup_valid),
        .lookup_key     (lookup_key),
        .clear_cmd      (clear_cmd),
        .table_entries  (table_entries),
        .result_valid   (result_valid),
        .result         (result),
        .lookup_cnt     (lookup_cnt),
        .hit_cnt        (hit_cnt),
        .miss_cnt       (miss_cnt)
    );

endmodule

// File: hw/bcam_match.sv
/* two-stage exact-match pipeline with lookup, hit and miss counters */
`timescale 1ns/100ps
`include "bcam_defs.svh"

module bcam_match (
    input  logic                                    core_clk_ifc,
    input  logic                                    reset,
    input  logic                                    lookup_valid,
    input  logic [`BCAM_KEY_W-1:0]                  lookup_key,
    input  logic                                    clear_cmd,
    input  bcam_pkg::bcam_entry_t [`BCAM_DEPTH-1:0] table_entries,
    output logic                                    result_valid,
    output bcam_pkg::bcam_result_t                  result,
    output logic [`BCAM_REG_W-1:0]                  lookup_cnt,
    output logic [`BCAM_REG_W-1:0]                  hit_cnt,
    output logic [`BCAM_REG_W-1:0]                  miss_cnt
);
    import bcam_pkg::*;

    logic [`BCAM_DEPTH-1:0]     match_vec;
    logic                       match_valid;
    logic                       hit_any;
    logic [`BCAM_ID_W-1:0]      hit_id;
    bcam_result_t               result_d;

    // stage one: compare every in-use entry
    always_ff @(posedge core_clk_ifc) begin
        for (int i = 0; i < `BCAM_DEPTH; i++) begin
            match_vec[i] <= table_entries[i].in_use && (table_entries[i].key == lookup_key);
        end
    end

    // stage two: lowest matching index wins
    always_comb begin
        hit_any = 1'b0;
        hit_id  = '0;
        for (int i = `BCAM_DEPTH - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                hit_any = 1'b1;
                hit_id  = `BCAM_ID_W'(i);
            end
        end
        result_d.hit   = hit_any;
        result_d.id    = hit_id;
        result_d.value = hit_any ? table_entries[hit_id].value : '0;
    end

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            match_valid  <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            match_valid  <= lookup_valid;
            result_valid <= match_valid;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        result <= result_d;
    end

    //////////////////////////////////////////////////////////////////////
    // counters, wrap at 32 bits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (reset || clear_cmd) begin
            lookup_cnt <= '0;
            hit_cnt    <= '0;
            miss_cnt   <= '0;
        end else if (result_valid) begin
            lookup_cnt <= lookup_cnt + 1'b1;
            if (result.hit)
                hit_cnt <= hit_cnt + 1'b1;
            else
                miss_cnt <= miss_cnt + 1'b1;
        end
    end

endmodule

// File: hw/bcam_entry_store.sv
/* entry table with single-entry read/write and the clear-all sweep */
`timescale 1ns/100ps
`include "bcam_defs.svh"

module bcam_entry_store (
    input  logic                                    core_clk_ifc,
    input  logic                                    reset,
    input  logic                                    rd_cmd,
    input  logic                                    wr_cmd,
    input  logic                                    clear_cmd,
    input  logic [`BCAM_ID_W-1:0]                   cmd_id,
    input  bcam_pkg::bcam_entry_t                   wr_entry,
    output bcam_pkg::bcam_entry_t                   rd_entry,
    output logic                                    clear_busy,
    output bcam_pkg::bcam_entry_t [`BCAM_DEPTH-1:0] table_entries
);
    import bcam_pkg::*;

    bcam_entry_t [`BCAM_DEPTH-1:0]  entries;
    logic [`BCAM_ID_W-1:0]          sweep_idx;
    logic                           sweep_last;

    assign table_entries = entries;
    assign sweep_last    = (sweep_idx == `BCAM_ID_W'(`BCAM_DEPTH - 1));

    //////////////////////////////////////////////////////////////////////
    // table update
    //////////////////////////////////////////////////////////////////////

    // only the in-use flags are cleared by reset
    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            for (int i = 0; i < `BCAM_DEPTH; i++) begin
                entries[i].in_use <= 1'b0;
            end
        end else if (clear_busy) begin
            // writes are dropped during the sweep
            entries[sweep_idx].in_use <= 1'b0;
        end else if (wr_cmd) begin
            entries[cmd_id] <= wr_entry;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rd_cmd) begin
            rd_entry <= entries[cmd_id];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // clear sweep, one entry per cycle
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            clear_busy <= 1'b0;
            sweep_idx  <= '0;
        end else if (clear_cmd) begin
            clear_busy <= 1'b1;
            sweep_idx  <= '0;
        end else if (clear_busy) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_last) begin
                clear_busy <= 1'b0;
            end
        end
    end

endmodule

// File: hw/bcam_csr.sv
/* register decode, staging registers, table command pulses and
   registered read data */
`timescale 1ns/100ps
`include "bcam_defs.svh"

module bcam_csr (
    input  logic                        core_clk_ifc,
    input  logic                        reset,
    input  logic                        reg_wr,
    input  logic                        reg_rd,
    input  logic [`BCAM_ADDR_W-1:0]     reg_addr,
    input  logic [`BCAM_REG_W-1:0]      reg_wdata,
    output logic [`BCAM_REG_W-1:0]      reg_rdata,
    input  bcam_pkg::bcam_entry_t       rd_entry,
    input  logic                        clear_busy,
    input  logic [`BCAM_REG_W-1:0]      lookup_cnt,
    input  logic [`BCAM_REG_W-1:0]      hit_cnt,
    input  logic [`BCAM_REG_W-1:0]      miss_cnt,
    output logic                        rd_cmd,
    output logic                        wr_cmd,
    output logic                        clear_cmd,
    output logic [`BCAM_ID_W-1:0]       cmd_id,
    output bcam_pkg::bcam_entry_t       wr_entry
);
    import bcam_pkg::*;

    bcam_ctrl_t                 ctrl_in;
    bcam_ctrl_t                 ctrl_out;
    bcam_entry_t                stage;
    logic                       ctrl_wr;
    logic                       cmd_idle;
    logic                       rd_load;
    logic [`BCAM_ID_W-1:0]      entry_id;
    logic [`BCAM_REG_W-1:0]     emu_mode;
    logic [`BCAM_REG_W-1:0]     rdata_d;

    assign ctrl_in  = reg_wdata;
    assign ctrl_wr  = reg_wr && (reg_addr == `BCAM_ADDR_W'(`BCAM_REG_CTRL));
    // one command at a time
    assign cmd_idle = !rd_cmd && !wr_cmd;
    assign cmd_id   = entry_id;
    assign wr_entry = stage;

    //////////////////////////////////////////////////////////////////////
    // command pulses
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            rd_cmd    <= 1'b0;
            wr_cmd    <= 1'b0;
            clear_cmd <= 1'b0;
            rd_load   <= 1'b0;
        end else begin
            // write wins when both bits are set
            wr_cmd    <= ctrl_wr && ctrl_in.wr && cmd_idle;
            rd_cmd    <= ctrl_wr && ctrl_in.rd && !ctrl_in.wr && cmd_idle;
            clear_cmd <= ctrl_wr && ctrl_in.rst;
            // store output is valid one edge after rd_cmd
            rd_load   <= rd_cmd;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // staging and scratch registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            entry_id <= '0;
            emu_mode <= '0;
        end else if (reg_wr) begin
            if (reg_addr == `BCAM_ADDR_W'(`BCAM_REG_ENTRY_ID))
                entry_id <= reg_wdata[`BCAM_ID_W-1:0];
            if (reg_addr == `BCAM_ADDR_W'(`BCAM_REG_EMU_MODE))
                emu_mode <= reg_wdata;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            stage <= '0;
        end else if (rd_load) begin
            stage <= rd_entry;
        end else if (reg_wr) begin
            case (reg_addr)
                `BCAM_ADDR_W'(`BCAM_REG_CTRL):
                    stage.in_use <= ctrl_in.in_use;
                `BCAM_ADDR_W'(`BCAM_REG_DATA0):
                    stage.key <= reg_wdata[`BCAM_KEY_W-1:0];
                // mask slot at DATA0+1 is ignored
                `BCAM_ADDR_W'(`BCAM_REG_DATA0 + 2):
                    stage.value[`BCAM_REG_W-1:0] <= reg_wdata;
                `BCAM_ADDR_W'(`BCAM_REG_DATA0 + 3):
                    stage.value[`BCAM_VALUE_W-1:`BCAM_REG_W] <= reg_wdata;
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read data
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl_out        = '0;
        ctrl_out.in_use = stage.in_use;
        ctrl_out.rsvd   = '0;
        // busy from the rst write until the sweep is done
        ctrl_out.rst    = clear_cmd || clear_busy;
        ctrl_out.wr     = wr_cmd;
        ctrl_out.rd     = rd_cmd;
    end

    always_comb begin
        case (reg_addr)
            `BCAM_ADDR_W'(`BCAM_REG_CTRL):       rdata_d = ctrl_out;
            `BCAM_ADDR_W'(`BCAM_REG_ENTRY_ID):   rdata_d = `BCAM_REG_W'(entry_id);
            `BCAM_ADDR_W'(`BCAM_REG_EMU_MODE):   rdata_d = emu_mode;
            `BCAM_ADDR_W'(`BCAM_REG_LOOKUP_CNT): rdata_d = lookup_cnt;
            `BCAM_ADDR_W'(`BCAM_REG_HIT_CNT):    rdata_d = hit_cnt;
            `BCAM_ADDR_W'(`BCAM_REG_MISS_CNT):   rdata_d = miss_cnt;
            `BCAM_ADDR_W'(`BCAM_REG_DATA0):      rdata_d = `BCAM_REG_W'(stage.key);
            `BCAM_ADDR_W'(`BCAM_REG_DATA0 + 2):
                rdata_d = stage.value[`BCAM_REG_W-1:0];
            `BCAM_ADDR_W'(`BCAM_REG_DATA0 + 3):
                rdata_d = stage.value[`BCAM_VALUE_W-1:`BCAM_REG_W];
            default:                             rdata_d = '0;
        endcase
    end

    // held until the next read strobe
    always_ff @(posedge core_clk_ifc) begin
        if (reset) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rdata_d;
        end
    end

endmodule

// File: hw/bcam_pkg.sv
/* shared types: table entry, decoded control word and lookup result */
`include "bcam_defs.svh"

package bcam_pkg;

    // one table row
    typedef struct packed {
        logic                       in_use;
        logic [`BCAM_KEY_W-1:0]     key;
        logic [`BCAM_VALUE_W-1:0]   value;
    } bcam_entry_t;

    // control register layout, msb first
    typedef struct packed {
        logic                                           in_use;
        logic [`BCAM_CTRL_IN_USE-`BCAM_CTRL_RST-2:0]    rsvd;
        logic                                           rst;
        logic                                           wr;
        logic                                           rd;
    } bcam_ctrl_t;

    // match pipeline output
    typedef struct packed {
        logic                       hit;
        logic [`BCAM_ID_W-1:0]      id;
        logic [`BCAM_VALUE_W-1:0]   value;
    } bcam_result_t;

endpackage

// File: hw/bcam_defs.svh
/* table geometry, register word offsets and control bit positions
   for the tiny BCAM */
`ifndef BCAM_DEFS_SVH
`define BCAM_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// table geometry
//////////////////////////////////////////////////////////////////////

`define BCAM_DEPTH          32
`define BCAM_ID_W           5
`define BCAM_KEY_W          20
`define BCAM_VALUE_W        64

// register bus
`define BCAM_REG_W          32
`define BCAM_ADDR_W         6

//////////////////////////////////////////////////////////////////////
// register word offsets
//////////////////////////////////////////////////////////////////////

`define BCAM_REG_CTRL       0
`define BCAM_REG_ENTRY_ID   1
`define BCAM_REG_EMU_MODE   2
`define BCAM_REG_LOOKUP_CNT 3
`define BCAM_REG_HIT_CNT    4
`define BCAM_REG_MISS_CNT   5
// key at DATA0, mask slot at DATA0+1, value low/high at DATA0+2/+3
`define BCAM_REG_DATA0      16

// control word bits
`define BCAM_CTRL_RD        0
`define BCAM_CTRL_WR        1
`define BCAM_CTRL_RST       2
`define BCAM_CTRL_IN_USE    31

`endif
